/* xcvr_csr_defines.svh */
/*
 * Register map, bit offsets, widths and fixed ID values of the channel CSR block.
 * Include wherever an address, an offset or a width is needed.
 */
`ifndef XCVR_CSR_DEFINES_SVH
`define XCVR_CSR_DEFINES_SVH

// Bus widths and resync depth
`define CSR_ADDR_W                 4
`define CSR_DATA_W                 16
`define CSR_SYNC_STAGES            2

// ********************
// Register addresses
`define CSR_ADDR_DUMMY             4'd0
`define CSR_ADDR_OC                4'd2
`define CSR_ADDR_PRBS              4'd3
`define CSR_ADDR_SLPBK             4'd6
`define CSR_ADDR_STATUS            4'd7
`define CSR_ADDR_ID                4'd8
`define CSR_ADDR_RSTCTL            4'd10

// ********************
// Bit offsets inside each register
`define CSR_DUMMY_OFST             0
`define CSR_OC_CALEN_OFST          0
`define CSR_OC_CALDONE_OFST        1
`define CSR_PRBS_CLR_OFST          0
`define CSR_PRBS_8G_ERR_OFST       1
`define CSR_PRBS_8G_DONE_OFST      2
`define CSR_PRBS_10G_ERR_OFST      3
`define CSR_PRBS_10G_DONE_OFST     4
`define CSR_SLPBK_EN_OFST          0
`define CSR_STATUS_PLL_LOCKED_OFST 0
`define CSR_STATUS_LOCK_FLAG_OFST  1
`define CSR_STATUS_TX_DIG_RST_OFST 2
`define CSR_STATUS_RX_DIG_RST_OFST 3
`define CSR_RSTCTL_TX_OVR_OFST     0
`define CSR_RSTCTL_TX_DIG_VAL_OFST 1
`define CSR_RSTCTL_RX_OVR_OFST     2
`define CSR_RSTCTL_RX_DIG_VAL_OFST 3
`define CSR_RSTCTL_RX_ANA_VAL_OFST 4
`define CSR_ID_TX_OFST             0
`define CSR_ID_RX_OFST             1
`define CSR_ID_ATT_OFST            2
`define CSR_ID_PLL_TYPE_OFST       3
`define CSR_ID_PLL_TYPE_W          2

// Fixed channel configuration of TX and RX with a CMU PLL and no ATT
`define CSR_ID_TX_VAL              1'b1
`define CSR_ID_RX_VAL              1'b1
`define CSR_ID_ATT_VAL             1'b0
`define CSR_ID_PLL_TYPE_VAL        2'd1

`endif

/* xcvr_csr_pkg.sv */
/*
 * Types shared by the channel CSR modules: bus words, write strobes,
 * and the control and status bundles passed between blocks.
 */
`include "xcvr_csr_defines.svh"

package xcvr_csr_pkg;

  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`CSR_DATA_W-1:0] csr_data_t;

  // One strobe per writable register
  typedef struct packed {
    logic dummy;
    logic oc;
    logic prbs;
    logic slpbk;
    logic status;
    logic rstctl;
  } csr_wr_sel_t;

  // ********************
  // Control register bits
  typedef struct packed {
    logic spare;
    logic dummy;
    logic hardoccalen;
    logic prbs_err_clr;
    logic seriallpbken;
    logic tx_rst_ovr;
    logic tx_digital_rst_n_val;
    logic rx_rst_ovr;
    logic rx_digital_rst_n_val;
    logic rx_analog_rst_n_val;
  } xcvr_ctrl_t;

  // Raw channel status asynchronous to av_clk
  typedef struct packed {
    logic hardoccaldone;
    logic prbs_8g_done;
    logic prbs_8g_err;
    logic prbs_10g_done;
    logic prbs_10g_err;
    logic pll_locked;
    logic tx_digital_reset;
    logic rx_digital_reset;
  } xcvr_stat_in_t;

  // Resynchronized status plus the sticky lock flag
  typedef struct packed {
    xcvr_stat_in_t sync;
    logic          pll_locked_flag;
  } xcvr_stat_t;

endpackage

/* csr_access.sv */
/*
 * Host side of the CSR block. Turns the write address into one strobe per
 * register and returns the addressed word one cycle after av_read.
 */
`timescale 1ns/1ps
`include "xcvr_csr_defines.svh"

module csr_access (
  input  logic                     av_clk,
  input  logic                     av_reset,
  input  xcvr_csr_pkg::csr_addr_t  av_address,
  input  logic                     av_write,
  input  logic                     av_read,
  input  xcvr_csr_pkg::xcvr_ctrl_t ctrl,
  input  xcvr_csr_pkg::xcvr_stat_t stat,
  output xcvr_csr_pkg::csr_wr_sel_t wr_sel,
  output xcvr_csr_pkg::csr_data_t  av_readdata
);
  import xcvr_csr_pkg::*;

  csr_data_t rd_dummy;
  csr_data_t rd_oc;
  csr_data_t rd_prbs;
  csr_data_t rd_slpbk;
  csr_data_t rd_status;
  csr_data_t rd_id;
  csr_data_t rd_rstctl;

  // ********************
  // Write strobes qualified by av_write
  assign wr_sel.dummy  = av_write && (av_address == `CSR_ADDR_DUMMY);
  assign wr_sel.oc     = av_write && (av_address == `CSR_ADDR_OC);
  assign wr_sel.prbs   = av_write && (av_address == `CSR_ADDR_PRBS);
  assign wr_sel.slpbk  = av_write && (av_address == `CSR_ADDR_SLPBK);
  assign wr_sel.status = av_write && (av_address == `CSR_ADDR_STATUS);
  assign wr_sel.rstctl = av_write && (av_address == `CSR_ADDR_RSTCTL);

  // ********************
  // Readback words with unlisted bits left at zero
  always_comb begin
    rd_dummy  = '0;
    rd_oc     = '0;
    rd_prbs   = '0;
    rd_slpbk  = '0;
    rd_status = '0;
    rd_id     = '0;
    rd_rstctl = '0;

    rd_dummy[`CSR_DUMMY_OFST]               = ctrl.dummy;
    rd_oc[`CSR_OC_CALEN_OFST]               = ctrl.hardoccalen;
    rd_oc[`CSR_OC_CALDONE_OFST]             = stat.sync.hardoccaldone;
    rd_prbs[`CSR_PRBS_CLR_OFST]             = ctrl.prbs_err_clr;
    rd_prbs[`CSR_PRBS_8G_ERR_OFST]          = stat.sync.prbs_8g_err;
    rd_prbs[`CSR_PRBS_8G_DONE_OFST]         = stat.sync.prbs_8g_done;
    rd_prbs[`CSR_PRBS_10G_ERR_OFST]         = stat.sync.prbs_10g_err;
    rd_prbs[`CSR_PRBS_10G_DONE_OFST]        = stat.sync.prbs_10g_done;
    rd_slpbk[`CSR_SLPBK_EN_OFST]            = ctrl.seriallpbken;
    rd_status[`CSR_STATUS_PLL_LOCKED_OFST]  = stat.sync.pll_locked;
    rd_status[`CSR_STATUS_LOCK_FLAG_OFST]   = stat.pll_locked_flag;
    rd_status[`CSR_STATUS_TX_DIG_RST_OFST]  = stat.sync.tx_digital_reset;
    rd_status[`CSR_STATUS_RX_DIG_RST_OFST]  = stat.sync.rx_digital_reset;
    rd_rstctl[`CSR_RSTCTL_TX_OVR_OFST]      = ctrl.tx_rst_ovr;
    rd_rstctl[`CSR_RSTCTL_TX_DIG_VAL_OFST]  = ctrl.tx_digital_rst_n_val;
    rd_rstctl[`CSR_RSTCTL_RX_OVR_OFST]      = ctrl.rx_rst_ovr;
    rd_rstctl[`CSR_RSTCTL_RX_DIG_VAL_OFST]  = ctrl.rx_digital_rst_n_val;
    rd_rstctl[`CSR_RSTCTL_RX_ANA_VAL_OFST]  = ctrl.rx_analog_rst_n_val;

    // Channel identity, fixed at build time
    rd_id[`CSR_ID_TX_OFST]  = `CSR_ID_TX_VAL;
    rd_id[`CSR_ID_RX_OFST]  = `CSR_ID_RX_VAL;
    rd_id[`CSR_ID_ATT_OFST] = `CSR_ID_ATT_VAL;
    rd_id[`CSR_ID_PLL_TYPE_OFST +: `CSR_ID_PLL_TYPE_W] = `CSR_ID_PLL_TYPE_VAL;
  end

  // Registered read mux that returns zero without av_read
  always_ff @(posedge av_clk or posedge av_reset) begin
    if (av_reset) begin
      av_readdata <= '0;
    end else if (!av_read) begin
      av_readdata <= '0;
    end else begin
      case (av_address)
        `CSR_ADDR_DUMMY:  av_readdata <= rd_dummy;
        `CSR_ADDR_OC:     av_readdata <= rd_oc;
        `CSR_ADDR_PRBS:   av_readdata <= rd_prbs;
        `CSR_ADDR_SLPBK:  av_readdata <= rd_slpbk;
        `CSR_ADDR_STATUS: av_readdata <= rd_status;
        `CSR_ADDR_ID:     av_readdata <= rd_id;
        `CSR_ADDR_RSTCTL: av_readdata <= rd_rstctl;
        default:          av_readdata <= '0;
      endcase
    end
  end

endmodule

/* xcvr_ctrl_regs.sv */
/*
 * Writable control bits of the channel. Each register loads its bits from
 * av_writedata on its strobe; the bundle drives the channel controls.
 */
`timescale 1ns/1ps
`include "xcvr_csr_defines.svh"

module xcvr_ctrl_regs (
  input  logic                      av_clk,
  input  logic                      av_reset,
  input  xcvr_csr_pkg::csr_wr_sel_t wr_sel,
  input  xcvr_csr_pkg::csr_data_t   av_writedata,
  output xcvr_csr_pkg::xcvr_ctrl_t  ctrl
);
  import xcvr_csr_pkg::*;

  xcvr_ctrl_t ctrl_q;

  always_ff @(posedge av_clk or posedge av_reset) begin
    if (av_reset) begin
      ctrl_q <= '0;
    end else begin
      // ********************
      // DUMMY scratch bit
      if (wr_sel.dummy) begin
        ctrl_q.dummy <= av_writedata[`CSR_DUMMY_OFST];
      end

      // Offset cancellation enable
      if (wr_sel.oc) begin
        ctrl_q.hardoccalen <= av_writedata[`CSR_OC_CALEN_OFST];
      end

      // PRBS error counter clear
      if (wr_sel.prbs) begin
        ctrl_q.prbs_err_clr <= av_writedata[`CSR_PRBS_CLR_OFST];
      end

      // Serial loopback
      if (wr_sel.slpbk) begin
        ctrl_q.seriallpbken <= av_writedata[`CSR_SLPBK_EN_OFST];
      end

      // ********************
      // TX and RX reset overrides loaded together
      if (wr_sel.rstctl) begin
        ctrl_q.tx_rst_ovr           <= av_writedata[`CSR_RSTCTL_TX_OVR_OFST];
        ctrl_q.tx_digital_rst_n_val <= av_writedata[`CSR_RSTCTL_TX_DIG_VAL_OFST];
        ctrl_q.rx_rst_ovr           <= av_writedata[`CSR_RSTCTL_RX_OVR_OFST];
        ctrl_q.rx_digital_rst_n_val <= av_writedata[`CSR_RSTCTL_RX_DIG_VAL_OFST];
        ctrl_q.rx_analog_rst_n_val  <= av_writedata[`CSR_RSTCTL_RX_ANA_VAL_OFST];
      end

      // Spare bit has no writer and holds its reset value
      ctrl_q.spare <= 1'b0;
    end
  end

  assign ctrl = ctrl_q;

endmodule

/* xcvr_status_sync.sv */
/*
 * Brings the channel status inputs into the av_clk domain and keeps the
 * sticky PLL-locked flag. Output is valid CSR_SYNC_STAGES cycles after input.
 */
`timescale 1ns/1ps
`include "xcvr_csr_defines.svh"

module xcvr_status_sync (
  input  logic                        av_clk,
  input  logic                        av_reset,
  input  xcvr_csr_pkg::xcvr_stat_in_t stat_in,
  input  logic                        wr_status,
  input  xcvr_csr_pkg::csr_data_t     av_writedata,
  output xcvr_csr_pkg::xcvr_stat_t    stat
);
  import xcvr_csr_pkg::*;

  xcvr_stat_in_t sync_q [`CSR_SYNC_STAGES];
  logic          locked_flag_q;

  // ********************
  // Resync chain for all status bits in parallel
  always_ff @(posedge av_clk or posedge av_reset) begin
    if (av_reset) begin
      for (int i = 0; i < `CSR_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= stat_in;
      for (int i = 1; i < `CSR_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // ********************
  // Sticky lock flag
  // Host write wins over a loss of lock in the same cycle
  always_ff @(posedge av_clk or posedge av_reset) begin
    if (av_reset) begin
      locked_flag_q <= 1'b0;
    end else if (wr_status) begin
      locked_flag_q <= av_writedata[`CSR_STATUS_LOCK_FLAG_OFST];
    end else if (!sync_q[`CSR_SYNC_STAGES-1].pll_locked) begin
      locked_flag_q <= 1'b0;
    end
  end

  assign stat.sync            = sync_q[`CSR_SYNC_STAGES-1];
  assign stat.pll_locked_flag = locked_flag_q;

endmodule

/* xcvr_csr_top.sv */
/*
 * CSR block of one transceiver channel, reached over a 4-bit address,
 * 16-bit data Avalon-MM port with fixed one-cycle read latency.
 */
`timescale 1ns/1ps

module xcvr_csr_top (
  // Avalon-MM slave
  input  logic                      av_clk,
  input  logic                      av_reset,
  input  xcvr_csr_pkg::csr_data_t   av_writedata,
  input  xcvr_csr_pkg::csr_addr_t   av_address,
  input  logic                      av_write,
  input  logic                      av_read,
  output xcvr_csr_pkg::csr_data_t   av_readdata,
  // Channel status
  input  logic                      hardoccaldone,
  input  logic                      pcs_8g_prbs_done,
  input  logic                      pcs_8g_prbs_err,
  input  logic                      pcs_10g_prbs_done,
  input  logic                      pcs_10g_prbs_err,
  input  logic                      stat_pll_locked,
  input  logic                      stat_tx_digital_reset,
  input  logic                      stat_rx_digital_reset,
  // Channel controls
  output logic                      hardoccalen,
  output logic                      pcs_10g_prbs_err_clr,
  output logic                      seriallpbken,
  output logic                      tx_rst_ovr,
  output logic                      tx_digital_rst_n_val,
  output logic                      rx_rst_ovr,
  output logic                      rx_digital_rst_n_val,
  output logic                      rx_analog_rst_n_val
);
  import xcvr_csr_pkg::*;

  csr_wr_sel_t   wr_sel;
  xcvr_ctrl_t    ctrl;
  xcvr_stat_in_t stat_in;
  xcvr_stat_t    stat;

  // Gather raw status into one bundle
  assign stat_in.hardoccaldone    = hardoccaldone;
  assign stat_in.prbs_8g_done     = pcs_8g_prbs_done;
  assign stat_in.prbs_8g_err      = pcs_8g_prbs_err;
  assign stat_in.prbs_10g_done    = pcs_10g_prbs_done;
  assign stat_in.prbs_10g_err     = pcs_10g_prbs_err;
  assign stat_in.pll_locked       = stat_pll_locked;
  assign stat_in.tx_digital_reset = stat_tx_digital_reset;
  assign stat_in.rx_digital_reset = stat_rx_digital_reset;

  csr_access u_access (
    .av_clk      (av_clk),
    .av_reset    (av_reset),
    .av_address  (av_address),
    .av_write    (av_write),
    .av_read     (av_read),
    .ctrl        (ctrl),
    .stat        (stat),
    .wr_sel      (wr_sel),
    .av_readdata (av_readdata)
  );

  xcvr_ctrl_regs u_ctrl (
    .av_clk       (av_clk),
    .av_reset     (av_reset),
    .wr_sel       (wr_sel),
    .av_writedata (av_writedata),
    .ctrl         (ctrl)
  );

  xcvr_status_sync u_status (
    .av_clk       (av_clk),
    .av_reset     (av_reset),
    .stat_in      (stat_in),
    .wr_status    (wr_sel.status),
    .av_writedata (av_writedata),
    .stat         (stat)
  );

  // ********************
  // Control bundle onto the channel pins
  assign hardoccalen          = ctrl.hardoccalen;
  assign pcs_10g_prbs_err_clr = ctrl.prbs_err_clr;
  assign seriallpbken         = ctrl.seriallpbken;
  assign tx_rst_ovr           = ctrl.tx_rst_ovr;
  assign tx_digital_rst_n_val = ctrl.tx_digital_rst_n_val;
  assign rx_rst_ovr           = ctrl.rx_rst_ovr;
  assign rx_digital_rst_n_val = ctrl.rx_digital_rst_n_val;
  assign rx_analog_rst_n_val  = ctrl.rx_analog_rst_n_val;

endmodule

/* xcvr_csr_chk.sv */
/*
 * Bus and lock-flag assertions for the channel CSR block,
 * bound into every xcvr_csr_top instance.
 */
`timescale 1ns/1ps

module xcvr_csr_chk (
  input logic                      av_clk,
  input logic                      av_reset,
  input logic                      av_read,
  input logic                      av_write,
  input xcvr_csr_pkg::csr_data_t   av_readdata,
  input logic                      stat_pll_locked,
  input xcvr_csr_pkg::csr_wr_sel_t wr_sel,
  input xcvr_csr_pkg::xcvr_ctrl_t  ctrl,
  input xcvr_csr_pkg::xcvr_stat_t  stat
);

  // Number of failed assertions
  int fail_count = 0;

  // Read data falls back to zero after a cycle without av_read
  a_rd_idle_zero: assert property (@(posedge av_clk) disable iff (av_reset)
    !av_read |=> (av_readdata == '0))
    else begin
      $error("av_readdata is not zero after a cycle without av_read");
      fail_count++;
    end

  a_ctrl_stable: assert property (@(posedge av_clk) disable iff (av_reset)
    !av_write |=> $stable(ctrl))
    else begin
      $error("control outputs changed without a host write");
      fail_count++;
    end

  // Two sync stages plus the flag flop
  a_flag_clear: assert property (@(posedge av_clk) disable iff (av_reset)
    ($past(!stat_pll_locked, 3) && !$past(wr_sel.status)) |-> !stat.pll_locked_flag)
    else begin
      $error("locked flag still set three cycles after loss of lock");
      fail_count++;
    end

endmodule

bind xcvr_csr_top xcvr_csr_chk u_chk (
  .av_clk          (av_clk),
  .av_reset        (av_reset),
  .av_read         (av_read),
  .av_write        (av_write),
  .av_readdata     (av_readdata),
  .stat_pll_locked (stat_pll_locked),
  .wr_sel          (wr_sel),
  .ctrl            (ctrl),
  .stat            (stat)
);

/* tb_csr_monitor.sv */
/*
 * Checker for the CSR testbench. Compares av_readdata one cycle after a read
 * and the control pins one cycle after a write, and keeps the error counts.
 */
`timescale 1ns/1ps

module tb_csr_monitor (
  input  logic                     av_clk,
  input  logic                     av_reset,
  input  xcvr_csr_pkg::csr_data_t  av_readdata,
  input  xcvr_csr_pkg::xcvr_ctrl_t ctrl_obs,
  input  logic                     rd_check,
  input  logic                     ctrl_check,
  input  xcvr_csr_pkg::csr_data_t  exp_data,
  input  int                       test_num,
  output int                       err_count,
  output int                       check_count
);
  import xcvr_csr_pkg::*;

  logic      rd_pend;
  logic      ctrl_pend;
  csr_data_t exp_q;
  int        test_q;

  // Requests are seen at the edge that performs the access,
  // the result is compared at the following edge
  always_ff @(posedge av_clk or posedge av_reset) begin
    if (av_reset) begin
      rd_pend     <= 1'b0;
      ctrl_pend   <= 1'b0;
      exp_q       <= '0;
      test_q      <= 0;
      err_count   <= 0;
      check_count <= 0;
    end else begin
      if (rd_pend) begin
        check_count <= check_count + 1;
        if (av_readdata !== exp_q) begin
          $display("ERR %0t: test %0d read returned %h, expected %h",
                   $time, test_q, av_readdata, exp_q);
          err_count <= err_count + 1;
        end
      end else if (ctrl_pend) begin
        check_count <= check_count + 1;
        // Low 8 bits of the control layout are the output pins
        if (ctrl_obs[7:0] !== exp_q[7:0]) begin
          $display("ERR %0t: test %0d control pins are %h, expected %h",
                   $time, test_q, ctrl_obs[7:0], exp_q[7:0]);
          err_count <= err_count + 1;
        end
      end
      rd_pend   <= rd_check;
      ctrl_pend <= ctrl_check;
      exp_q     <= exp_data;
      test_q    <= test_num;
    end
  end

endmodule

/* tb_xcvr_csr.sv */
/*
 * Testbench top for the channel CSR block. Replays csr_stim.txt on the
 * Avalon-MM port, hands expected values to the checker and reports per test.
 */
`timescale 1ns/1ps

module tb_xcvr_csr;
  import xcvr_csr_pkg::*;

  localparam int max_ops = 128;

  logic          av_clk;
  logic          av_reset;
  logic          av_write;
  logic          av_read;
  csr_addr_t     av_address;
  csr_data_t     av_writedata;
  csr_data_t     av_readdata;
  xcvr_stat_in_t stat_drv;
  xcvr_ctrl_t    ctrl_obs;
  logic          hardoccalen;
  logic          prbs_err_clr;
  logic          seriallpbken;
  logic          tx_rst_ovr;
  logic          tx_digital_rst_n_val;
  logic          rx_rst_ovr;
  logic          rx_digital_rst_n_val;
  logic          rx_analog_rst_n_val;

  // Checker handshake
  logic          rd_check;
  logic          ctrl_check;
  csr_data_t     exp_data;
  int            test_num;
  int            err_count;
  int            check_count;

  // Stim file image with five words per line
  logic [15:0]   stim_mem [0:5*max_ops-1];
  int            op_count = 0;
  int            cur_test = -1;
  int            errs_before = 0;
  int            tests_run = 0;
  int            tests_failed = 0;

  xcvr_csr_top dut (
    .av_clk                (av_clk),
    .av_reset              (av_reset),
    .av_writedata          (av_writedata),
    .av_address            (av_address),
    .av_write              (av_write),
    .av_read               (av_read),
    .av_readdata           (av_readdata),
    .hardoccaldone         (stat_drv.hardoccaldone),
    .pcs_8g_prbs_done      (stat_drv.prbs_8g_done),
    .pcs_8g_prbs_err       (stat_drv.prbs_8g_err),
    .pcs_10g_prbs_done     (stat_drv.prbs_10g_done),
    .pcs_10g_prbs_err      (stat_drv.prbs_10g_err),
    .stat_pll_locked       (stat_drv.pll_locked),
    .stat_tx_digital_reset (stat_drv.tx_digital_reset),
    .stat_rx_digital_reset (stat_drv.rx_digital_reset),
    .hardoccalen           (hardoccalen),
    .pcs_10g_prbs_err_clr  (prbs_err_clr),
    .seriallpbken          (seriallpbken),
    .tx_rst_ovr            (tx_rst_ovr),
    .tx_digital_rst_n_val  (tx_digital_rst_n_val),
    .rx_rst_ovr            (rx_rst_ovr),
    .rx_digital_rst_n_val  (rx_digital_rst_n_val),
    .rx_analog_rst_n_val   (rx_analog_rst_n_val)
  );

  // Pins gathered back into the control layout with no pin for dummy
  assign ctrl_obs = '{spare: 1'b0, dummy: 1'b0, hardoccalen: hardoccalen,
                      prbs_err_clr: prbs_err_clr, seriallpbken: seriallpbken,
                      tx_rst_ovr: tx_rst_ovr, tx_digital_rst_n_val: tx_digital_rst_n_val,
                      rx_rst_ovr: rx_rst_ovr, rx_digital_rst_n_val: rx_digital_rst_n_val,
                      rx_analog_rst_n_val: rx_analog_rst_n_val};

  tb_csr_monitor u_monitor (
    .av_clk      (av_clk),
    .av_reset    (av_reset),
    .av_readdata (av_readdata),
    .ctrl_obs    (ctrl_obs),
    .rd_check    (rd_check),
    .ctrl_check  (ctrl_check),
    .exp_data    (exp_data),
    .test_num    (test_num),
    .err_count   (err_count),
    .check_count (check_count)
  );

  initial begin
    av_clk = 1'b0;
    forever #50 av_clk = ~av_clk;
  end

  // Lines up to the first entry whose op code is not 1 to 4
  function automatic int count_ops();
    int n;
    n = 0;
    while (n < max_ops && stim_mem[5*n+1] >= 16'h0001 && stim_mem[5*n+1] <= 16'h0004) begin
      n++;
    end
    return n;
  endfunction

  task automatic idle_cycle();
    @(posedge av_clk);
    av_write   <= 1'b0;
    av_read    <= 1'b0;
    rd_check   <= 1'b0;
    ctrl_check <= 1'b0;
  endtask

  // ********************
  // One stim line with op 1 write, 2 read, 3 status inputs or 4 wait
  task automatic do_op(input int idx);
    logic [15:0] op;
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] exp_v;
    op    = stim_mem[5*idx+1];
    addr  = stim_mem[5*idx+2];
    data  = stim_mem[5*idx+3];
    exp_v = stim_mem[5*idx+4];
    idle_cycle();
    test_num <= int'(stim_mem[5*idx]);
    exp_data <= exp_v;
    case (op)
      16'h0001: begin
        av_write     <= 1'b1;
        av_address   <= addr[3:0];
        av_writedata <= data;
        ctrl_check   <= 1'b1;
      end
      16'h0002: begin
        av_read    <= 1'b1;
        av_address <= addr[3:0];
        rd_check   <= 1'b1;
      end
      16'h0003: stat_drv <= xcvr_stat_in_t'(data[7:0]);
      default:  repeat (int'(data) - 1) @(posedge av_clk);
    endcase
  endtask

  // Lets the last checks land before counting
  task automatic close_test();
    int errs;
    idle_cycle();
    repeat (2) @(posedge av_clk);
    errs = err_count - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d finished, all checks matched", cur_test);
    end else begin
      tests_failed++;
      $display("test %0d finished with %0d mismatches", cur_test, errs);
    end
    errs_before = err_count;
  endtask

  initial begin
    int t;
    av_reset     = 1'b1;
    av_write     = 1'b0;
    av_read      = 1'b0;
    av_address   = '0;
    av_writedata = '0;
    stat_drv     = '0;
    rd_check     = 1'b0;
    ctrl_check   = 1'b0;
    exp_data     = '0;
    test_num     = 0;
    $readmemh("csr_stim.txt", stim_mem);
    op_count = count_ops();
    repeat (3) @(posedge av_clk);
    av_reset <= 1'b0;
    for (int i = 0; i < op_count; i++) begin
      t = int'(stim_mem[5*i]);
      if (t != cur_test) begin
        if (cur_test >= 0) begin
          close_test();
        end
        cur_test = t;
      end
      do_op(i);
    end
    if (cur_test >= 0) begin
      close_test();
    end
    if (op_count == 0) begin
      $display("No usable stimulus lines were read from csr_stim.txt");
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, check_count, err_count, dut.u_chk.fail_count);
    if (op_count > 0 && err_count == 0 && tests_failed == 0 &&
        dut.u_chk.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // ********************
  // Watchdog sized from the stim length
  initial begin
    wait (op_count > 0);
    #((op_count + 50) * 100);
    $display("Timeout: the run did not finish within %0d clock periods", op_count + 50);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* csr_stim.txt */
// test op addr data expect (hex); op 1 write, 2 read, 3 set status, 4 wait cycles, f end
// write expect: pins calen, prbs clr, lpbk, tx ovr, tx val, rx ovr, rx val, rx ana (bit 7..0)
// status data bits 7..0: caldone, 8g done, 8g err, 10g done, 10g err, pll locked, tx rst, rx rst
1 2 0 0000 0000
1 2 2 0000 0000
1 2 3 0000 0000
1 2 6 0000 0000
1 2 a 0000 0000
1 1 8 ffff 0000
1 2 8 0000 000b
2 1 0 ffff 0000
2 2 0 0000 0001
2 1 2 ffff 0080
2 2 2 0000 0001
2 1 3 ffff 00c0
2 2 3 0000 0001
2 1 6 ffff 00e0
2 2 6 0000 0001
2 1 a ffff 00ff
2 2 a 0000 001f
2 1 0 0000 00ff
2 2 0 0000 0000
3 3 0 00ff 0000
3 4 0 0004 0000
3 2 7 0000 000d
3 2 3 0000 001f
3 2 2 0000 0003
4 3 0 0004 0000
4 4 0 0004 0000
4 1 7 0002 00ff
4 2 7 0000 0003
4 3 0 0000 0000
4 4 0 0004 0000
4 2 7 0000 0000
5 2 1 0000 0000
5 2 f 0000 0000
5 1 1 ffff 00ff
5 1 5 ffff 00ff
5 1 8 ffff 00ff
5 1 f ffff 00ff
5 2 8 0000 000b
5 2 0 0000 0000
5 2 a 0000 001f
5 2 6 0000 0001
5 2 2 0000 0001
0 f 0 0000 0000

/* sim.f */
+incdir+.
xcvr_csr_pkg.sv
csr_access.sv
xcvr_ctrl_regs.sv
xcvr_status_sync.sv
xcvr_csr_top.sv
xcvr_csr_chk.sv
tb_csr_monitor.sv
tb_xcvr_csr.sv

/* Makefile */
# Verilator flow for the channel CSR block
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_xcvr_csr

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_xcvr_csr -Mdir obj_dir
	./obj_dir/Vtb_xcvr_csr > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
